/* design/playfield_pkg.sv */
// package playfield_pkg: video widths, depth codes, group geometry and data types
package playfield_pkg;

    // bus and pixel widths
    localparam int ADDR_W       = 16;               // video memory word address bits
    localparam int WORD_W       = 16;               // memory data bits
    localparam int COLOR_W      = 8;                // colour index bits
    localparam int HRES_W       = 11;               // horizontal counter bits
    localparam int REPEAT_W     = 2;                // h/v repeat count bits

    // group geometry
    localparam int GROUP_PIXELS = 8;                // pixels per fetched group
    localparam int GROUP_WORDS  = 4;                // words per group at 8 bpp

    // AXI read response that the fetcher expects
    localparam logic [1:0] AXI_RESP_OKAY = 2'b00;

    typedef logic [ADDR_W-1:0]  addr_t;             // word address in video memory
    typedef logic [WORD_W-1:0]  word_t;             // one memory word
    typedef logic [COLOR_W-1:0] color_t;            // palette index
    typedef logic [HRES_W-1:0]  hres_t;             // horizontal position

    // up to four words of one group, word 0 in the lowest slot
    typedef word_t [GROUP_WORDS-1:0] group_t;

    // bitmap depth
    typedef enum logic {
        BPP_4 = 1'b0,                               // 2 words per group, nibble pixels
        BPP_8 = 1'b1                                // 4 words per group, byte pixels
    } bpp_t;

endpackage

/* design/scan_ctrl_if.sv */
// interface scan_ctrl_if: pixel-rate strobes from the scan timer to the pixel shifter
`timescale 1ns/1ns

interface scan_ctrl_if;
    logic start_o;                                  // load first group, begin output
    logic advance_o;                                // step to next pixel
    logic reload_o;                                 // with advance on 8th pixel, take next group
    logic active_o;                                 // level, pixels visible

    modport timer (
        output start_o, advance_o, reload_o, active_o
    );

    modport shifter (
        input  start_o, advance_o, reload_o, active_o
    );
endinterface

/* design/word_fetch.sv */
// module word_fetch: AXI4-Lite read master, group register, line start and vertical repeat
`timescale 1ns/1ns

module word_fetch import playfield_pkg::*; (
    input  logic                clk,
    input  logic                reset_i,            // sync, active high
    input  logic                fetch_start_i,      // line fetch begins
    input  logic                end_of_line_i,      // last cycle of the line
    input  logic                end_of_frame_i,     // last line of the frame
    input  logic                blank_i,            // playfield blanked
    input  addr_t               start_addr_i,       // frame start word address
    input  word_t               line_len_i,         // words added per displayed line
    input  bpp_t                bpp_i,              // bitmap depth
    input  logic [REPEAT_W-1:0] v_repeat_i,         // extra copies of each line
    output logic                ar_valid_o,
    output addr_t               ar_addr_o,
    input  logic                ar_ready_i,
    input  logic                r_valid_i,
    input  word_t               r_data_i,
    input  logic [1:0]          r_resp_i,           // not checked, data taken as is
    output logic                r_ready_o,
    output logic                group_valid_o,      // group offered to shifter
    output group_t              group_words_o,
    input  logic                group_ready_i       // shifter buffer empty
);

    typedef enum logic [1:0] {
        ST_IDLE,                                    // no fetching this line
        ST_ADDR,                                    // ar_valid up, wait ar_ready
        ST_DATA,                                    // r_ready up, wait r beat
        ST_OFFER                                    // group complete, wait for shifter
    } fetch_st_t;

    fetch_st_t              state_q;
    addr_t                  addr_q;                 // next word to read
    addr_t                  line_start_q;           // first word of current line
    logic [REPEAT_W-1:0]    v_count_q;              // lines left before advancing
    logic [1:0]             word_idx_q;             // slot for next beat
    group_t                 group_q;                // collected words
    logic                   run_q;                  // fetch enabled for this line
    logic                   restart_q;              // restart held back by outstanding read

    logic                   run_c;
    logic                   restart_c;
    logic                   restart_now_c;
    logic                   last_word_c;

    always_comb begin
        run_c       = fetch_start_i | (run_q & ~end_of_line_i);
        restart_c   = restart_q | fetch_start_i | end_of_line_i;
        // a read in flight must finish first, so only obey on the beat or when quiet
        restart_now_c = restart_c & ((state_q == ST_IDLE) || (state_q == ST_OFFER) ||
                                     ((state_q == ST_DATA) && r_valid_i));
        last_word_c = (bpp_i == BPP_4) ? (word_idx_q == 2'd1)
                                       : (word_idx_q == 2'(GROUP_WORDS - 1));
    end

    assign ar_valid_o    = (state_q == ST_ADDR);
    assign ar_addr_o     = addr_q;
    assign r_ready_o     = (state_q == ST_DATA);        // one read outstanding at most
    assign group_valid_o = (state_q == ST_OFFER);       // drops at once on restart
    assign group_words_o = group_q;

    // read sequencer
    always_ff @(posedge clk) begin
        if (reset_i) begin
            state_q    <= ST_IDLE;
            addr_q     <= '0;
            word_idx_q <= '0;
            run_q      <= 1'b0;
            restart_q  <= 1'b0;
        end else begin
            run_q     <= run_c;
            restart_q <= restart_c & ~restart_now_c;    // keep it until it can be obeyed
            if (restart_now_c) begin
                addr_q     <= line_start_q;             // back to the line start
                word_idx_q <= '0;
                state_q    <= run_c ? ST_ADDR : ST_IDLE;
            end else begin
                case (state_q)
                    ST_ADDR: begin
                        if (ar_ready_i) begin
                            state_q <= ST_DATA;         // address taken
                        end
                    end
                    ST_DATA: begin
                        if (r_valid_i) begin
                            addr_q <= addr_q + 1'b1;
                            if (last_word_c) begin
                                state_q <= ST_OFFER;    // valid rises next cycle
                            end else begin
                                word_idx_q <= word_idx_q + 1'b1;
                                state_q    <= ST_ADDR;
                            end
                        end
                    end
                    ST_OFFER: begin
                        if (group_ready_i) begin
                            word_idx_q <= '0;           // accepted, start next group
                            state_q    <= ST_ADDR;
                        end
                    end
                    default: begin
                        state_q <= ST_IDLE;             // wait for fetch start
                    end
                endcase
            end
        end
    end

    // word capture, slot order follows address order
    always_ff @(posedge clk) begin
        if ((state_q == ST_DATA) && r_valid_i) begin
            group_q[word_idx_q] <= r_data_i;
        end
    end

    // line start and vertical repeat
    always_ff @(posedge clk) begin
        if (reset_i || blank_i || end_of_frame_i) begin
            line_start_q <= start_addr_i;               // top of frame
            v_count_q    <= v_repeat_i;
        end else if (end_of_line_i) begin
            if (v_count_q == '0) begin
                v_count_q    <= v_repeat_i;
                line_start_q <= line_start_q + line_len_i;  // next source line
            end else begin
                v_count_q <= v_count_q - 1'b1;          // repeat same line
            end
        end
    end

endmodule

/* design/scan_timer.sv */
// module scan_timer: scanout window, horizontal repeat and group column strobes
`timescale 1ns/1ns

module scan_timer import playfield_pkg::*; (
    input  logic                clk,
    input  logic                reset_i,
    input  hres_t               h_count_i,          // horizontal position
    input  hres_t               vid_left_i,         // first visible column
    input  hres_t               vid_right_i,        // last visible column + 1
    input  logic                fetch_start_i,      // line fetch begins, arms the window
    input  logic                end_of_line_i,
    input  logic [REPEAT_W-1:0] h_repeat_i,         // extra copies of each pixel
    scan_ctrl_if.timer          ctrl
);

    hres_t                              left_q;     // window edges for this line
    hres_t                              right_q;
    logic                               armed_q;    // fetch started this line
    logic                               start_q;
    logic                               active_q;
    logic [REPEAT_W-1:0]                rep_q;      // cycles left on this pixel
    logic [$clog2(GROUP_PIXELS)-1:0]    col_q;      // pixel within the group

    logic                               start_c;
    logic                               stop_c;
    logic                               advance_c;

    always_comb begin
        start_c   = armed_q && (h_count_i == left_q);
        stop_c    = end_of_line_i || (h_count_i >= right_q);
        advance_c = active_q && !start_q && (rep_q == '0);  // first pixel held through start
    end

    assign ctrl.start_o   = start_q;
    assign ctrl.active_o  = active_q;
    assign ctrl.advance_o = advance_c;
    assign ctrl.reload_o  = advance_c && (col_q == $bits(col_q)'(GROUP_PIXELS - 1));

    always_ff @(posedge clk) begin
        if (reset_i) begin
            left_q   <= '0;
            right_q  <= '0;
            armed_q  <= 1'b0;
            start_q  <= 1'b0;
            active_q <= 1'b0;
            rep_q    <= '0;
            col_q    <= '0;
        end else begin
            if (end_of_line_i) begin
                armed_q <= 1'b0;
            end else if (fetch_start_i) begin
                armed_q <= 1'b1;
                left_q  <= vid_left_i;              // edges held for the whole line
                right_q <= vid_right_i;
            end
            start_q <= start_c;                     // one cycle after h == left
            if (stop_c) begin
                active_q <= 1'b0;                   // right edge or line end wins
            end else if (start_c) begin
                active_q <= 1'b1;
            end
            if (start_q) begin
                rep_q <= h_repeat_i;
                col_q <= '0;
            end else if (advance_c) begin
                rep_q <= h_repeat_i;
                col_q <= col_q + 1'b1;              // wraps after 8th pixel
            end else if (active_q) begin
                rep_q <= rep_q - 1'b1;
            end
        end
    end

endmodule

/* design/pixel_shifter.sv */
// module pixel_shifter: group buffer, depth expansion, pixel shift register and colour output
`timescale 1ns/1ns

module pixel_shifter import playfield_pkg::*; (
    input  logic        clk,
    input  logic        reset_i,
    input  logic        fetch_start_i,              // line start, buffer dropped
    input  bpp_t        bpp_i,
    input  color_t      border_color_i,
    input  color_t      colorbase_i,                // XORed into every index
    input  logic        group_valid_i,
    input  group_t      group_words_i,
    output logic        group_ready_o,
    scan_ctrl_if.shifter ctrl,
    output color_t      color_index_o,
    output logic        scanout_o                   // color_index_o is a visible pixel
);

    localparam int PIX_W = GROUP_PIXELS * COLOR_W;  // 64 bits of indices

    group_t             buf_q;                      // one group waiting
    logic               buf_full_q;
    logic [PIX_W-1:0]   shreg_q;                    // pixel being shown at the top
    logic [PIX_W-1:0]   shreg_c;
    logic [PIX_W-1:0]   expand_c;                   // buffer as eight indices
    logic               take_c;
    logic               accept_c;
    color_t             pixel_c;
    color_t             color_q;
    logic               scanout_q;

    // depth expansion, leftmost pixel in the top byte
    always_comb begin
        if (bpp_i == BPP_4) begin
            expand_c = {4'h0, buf_q[0][15:12], 4'h0, buf_q[0][11:8],
                        4'h0, buf_q[0][7:4],   4'h0, buf_q[0][3:0],
                        4'h0, buf_q[1][15:12], 4'h0, buf_q[1][11:8],
                        4'h0, buf_q[1][7:4],   4'h0, buf_q[1][3:0]};
        end else begin
            expand_c = {buf_q[0], buf_q[1], buf_q[2], buf_q[3]};   // high byte first
        end
    end

    always_comb begin
        take_c   = ctrl.start_o | ctrl.reload_o;    // reload always comes with advance
        accept_c = group_valid_i & ~buf_full_q & ~fetch_start_i;
        if (take_c) begin
            // empty buffer means underrun, show border until a group arrives
            shreg_c = buf_full_q ? expand_c : {GROUP_PIXELS{border_color_i}};
        end else if (ctrl.advance_o) begin
            shreg_c = {shreg_q[PIX_W-COLOR_W-1:0], border_color_i};
        end else begin
            shreg_c = shreg_q;
        end
        pixel_c = ctrl.active_o ? shreg_c[PIX_W-1 -: COLOR_W] : border_color_i;
    end

    assign group_ready_o = ~buf_full_q;
    assign color_index_o = color_q;
    assign scanout_o     = scanout_q;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            buf_full_q <= 1'b0;
            scanout_q  <= 1'b0;
        end else begin
            scanout_q <= ctrl.active_o;             // same delay as color_q
            if (fetch_start_i) begin
                buf_full_q <= 1'b0;
            end else if (accept_c) begin
                buf_full_q <= 1'b1;                 // only when empty, so no take clash
            end else if (take_c) begin
                buf_full_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept_c) begin
            buf_q <= group_words_i;
        end
        shreg_q <= shreg_c;
        color_q <= pixel_c ^ colorbase_i;           // new index one cycle after strobe
    end

endmodule

/* design/playfield_top.sv */
// module playfield_top: bitmap playfield with AXI4-Lite read port and pixel output
`timescale 1ns/1ns

module playfield_top import playfield_pkg::*; (
    input  logic                clk,
    input  logic                reset_i,
    // line timing
    input  hres_t               h_count_i,
    input  logic                fetch_start_i,
    input  logic                end_of_line_i,
    input  logic                end_of_frame_i,
    // window and colour
    input  hres_t               vid_left_i,
    input  hres_t               vid_right_i,
    input  color_t              border_color_i,
    input  color_t              colorbase_i,
    // addressing
    input  addr_t               start_addr_i,
    input  word_t               line_len_i,
    // mode
    input  bpp_t                bpp_i,
    input  logic [REPEAT_W-1:0] h_repeat_i,
    input  logic [REPEAT_W-1:0] v_repeat_i,
    input  logic                blank_i,
    // AXI4-Lite read channels
    output logic                ar_valid_o,
    output addr_t               ar_addr_o,
    input  logic                ar_ready_i,
    input  logic                r_valid_i,
    input  word_t               r_data_i,
    input  logic [1:0]          r_resp_i,
    output logic                r_ready_o,
    // pixels
    output color_t              color_index_o,
    output logic                scanout_o
);

    logic   group_valid;                            // fetcher -> shifter handshake
    logic   group_ready;
    group_t group_words;

    scan_ctrl_if ctrl_if ();

    word_fetch word_fetch_i (
        .clk            (clk),
        .reset_i        (reset_i),
        .fetch_start_i  (fetch_start_i),
        .end_of_line_i  (end_of_line_i),
        .end_of_frame_i (end_of_frame_i),
        .blank_i        (blank_i),
        .start_addr_i   (start_addr_i),
        .line_len_i     (line_len_i),
        .bpp_i          (bpp_i),
        .v_repeat_i     (v_repeat_i),
        .ar_valid_o     (ar_valid_o),
        .ar_addr_o      (ar_addr_o),
        .ar_ready_i     (ar_ready_i),
        .r_valid_i      (r_valid_i),
        .r_data_i       (r_data_i),
        .r_resp_i       (r_resp_i),
        .r_ready_o      (r_ready_o),
        .group_valid_o  (group_valid),
        .group_words_o  (group_words),
        .group_ready_i  (group_ready)
    );

    scan_timer scan_timer_i (
        .clk            (clk),
        .reset_i        (reset_i),
        .h_count_i      (h_count_i),
        .vid_left_i     (vid_left_i),
        .vid_right_i    (vid_right_i),
        .fetch_start_i  (fetch_start_i),
        .end_of_line_i  (end_of_line_i),
        .h_repeat_i     (h_repeat_i),
        .ctrl           (ctrl_if.timer)
    );

    pixel_shifter pixel_shifter_i (
        .clk            (clk),
        .reset_i        (reset_i),
        .fetch_start_i  (fetch_start_i),
        .bpp_i          (bpp_i),
        .border_color_i (border_color_i),
        .colorbase_i    (colorbase_i),
        .group_valid_i  (group_valid),
        .group_words_i  (group_words),
        .group_ready_o  (group_ready),
        .ctrl           (ctrl_if.shifter),
        .color_index_o  (color_index_o),
        .scanout_o      (scanout_o)
    );

endmodule

/* verif/playfield_tb.sv */
// testbench playfield_tb: clock, reset, AXI memory model, line driver, reference model, watchdog
`timescale 1ns/1ns

module playfield_tb import playfield_pkg::*;;

    localparam int CLK_PERIOD   = 40;
    localparam int RESET_CYCLES = 16;
    localparam int LINE_CYCLES  = 400;                  // h_count 0..399
    localparam int FETCH_H      = 4;                    // fetch_start position
    localparam int VID_LEFT     = 100;
    localparam int NUM_FRAMES   = 8;
    localparam int NUM_LINES    = 6;
    localparam int SEED         = 96201;
    localparam int WATCHDOG_NS  = (RESET_CYCLES + 8 + NUM_FRAMES * NUM_LINES * LINE_CYCLES)
                                  * CLK_PERIOD + 40_000;

    logic clk;
    logic reset_i;
    hres_t h_count_i;
    logic fetch_start_i, end_of_line_i, end_of_frame_i;
    hres_t vid_left_i, vid_right_i;
    color_t border_color_i, colorbase_i;
    addr_t start_addr_i;
    word_t line_len_i;
    bpp_t bpp_i;
    logic [REPEAT_W-1:0] h_repeat_i, v_repeat_i;
    logic blank_i;
    logic ar_valid_o, ar_ready_i, r_valid_i, r_ready_o;
    addr_t ar_addr_o;
    word_t r_data_i;
    logic [1:0] r_resp_i;
    color_t color_index_o;
    logic scanout_o;

    word_t mem [0:65535];                               // video memory contents
    logic [31:0] stim_rng;                              // config and memory fill
    logic [31:0] stall_rng;                             // memory model delays
    logic stall_en;                                     // memory may add wait cycles
    color_t expect_q [$];                               // expected indices of current line

    playfield_top playfield_top_i (.*);

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        if (actual !== expected) begin
            $display("ERROR %0t ns: %s: got 0x%0h, expected 0x%0h", $time, what, actual,
                     expected);
            $display("TEST FAIL");
            $fatal(1, "stopped at first mismatch");
        end
    endtask

    // index of pixel p of a line starting at word ls, before colour base
    function automatic color_t source_index(input addr_t ls, input bpp_t bpp, input int p);
        word_t w;
        if (bpp == BPP_8) begin
            w = mem[addr_t'(ls + p / 2)];               // two pixels per word
            return (p % 2 == 0) ? w[15:8] : w[7:0];     // high byte is left pixel
        end
        w = mem[addr_t'(ls + p / 4)];                   // four nibbles per word
        return {4'h0, w[15 - 4 * (p % 4) -: 4]};
    endfunction

    task automatic build_line(input addr_t ls);
        int n;
        n = int'(vid_right_i) - VID_LEFT;               // visible cycles
        expect_q.delete();
        for (int j = 0; j < n; j++) begin
            expect_q.push_back(source_index(ls, bpp_i, j / (int'(h_repeat_i) + 1)) ^ colorbase_i);
        end
    endtask

    task automatic pick_config(input int frame);
        logic [31:0] r;
        stim_rng = xorshift32(stim_rng);
        r = stim_rng;
        if (frame == 0) begin
            bpp_i = BPP_8;
        end else if (frame == 1) begin
            bpp_i = BPP_4;
        end else begin
            bpp_i = bpp_t'(r[0]);
        end
        h_repeat_i     = (frame < 2) ? 2'd0 : 2'(frame % 4);   // every repeat value covered
        v_repeat_i     = r[2:1];
        border_color_i = r[15:8];
        colorbase_i    = r[23:16];
        blank_i        = (frame == 3);
        stim_rng       = xorshift32(stim_rng);
        start_addr_i   = stim_rng[15:0];
        line_len_i     = stim_rng[31:16];
        stim_rng       = xorshift32(stim_rng);
        if (bpp_i == BPP_8 && h_repeat_i == 2'd0) begin
            // 9 fetch cycles per 8 pixels, prefetch covers about 64 pixels
            vid_right_i = hres_t'(VID_LEFT + 40 + stim_rng % 17);
            stall_en    = 1'b0;
        end else begin
            vid_right_i = hres_t'(180 + stim_rng % 81);
            stall_en    = 1'b1;
        end
    endtask

    // one video line, samples last cycle's outputs before driving the next count
    task automatic run_line(input int frame, input int line, input bit last_line);
        int seen;
        int n;
        seen = 0;
        n = expect_q.size();
        for (int h = 0; h < LINE_CYCLES; h++) begin
            @(negedge clk);
            if (scanout_o) begin
                seen++;
                if (seen <= n) begin
                    check_value(color_index_o, expect_q[seen-1],
                                $sformatf("frame %0d line %0d sample %0d", frame, line, seen - 1));
                end
            end
            h_count_i      = hres_t'(h);
            fetch_start_i  = (h == FETCH_H);
            end_of_line_i  = (h == LINE_CYCLES - 1);
            end_of_frame_i = last_line && (h == LINE_CYCLES - 1);
            if (end_of_frame_i && frame + 1 < NUM_FRAMES) begin
                pick_config(frame + 1);                 // sampled together with end of frame
            end
        end
        check_value(seen, n, $sformatf("scanout cycles in frame %0d line %0d", frame, line));
    endtask

    // AXI4-Lite read slave, 0 or 1 wait cycle per handshake, always OKAY
    initial begin : axi_memory
        logic  ar_hs;
        logic  r_hs;
        logic  rd_pending;
        logic  ar_held;
        logic  r_held;
        addr_t rd_addr;
        ar_ready_i = 1'b0;
        r_valid_i  = 1'b0;
        r_data_i   = '0;
        r_resp_i   = AXI_RESP_OKAY;
        ar_hs      = 1'b0;
        r_hs       = 1'b0;
        rd_pending = 1'b0;
        ar_held    = 1'b0;
        r_held     = 1'b0;
        rd_addr    = '0;
        forever begin
            @(negedge clk);
            if (reset_i) begin
                ar_ready_i = 1'b0;
                r_valid_i  = 1'b0;
                ar_hs      = 1'b0;
                r_hs       = 1'b0;
                rd_pending = 1'b0;
            end else begin
                if (ar_hs) begin                        // address taken at last edge
                    rd_pending = 1'b1;
                    ar_ready_i = 1'b0;
                    ar_held    = 1'b0;
                end
                if (r_hs) begin                         // beat taken at last edge
                    rd_pending = 1'b0;
                    r_valid_i  = 1'b0;
                    r_held     = 1'b0;
                end
                stall_rng = xorshift32(stall_rng);
                if (ar_valid_o && !ar_ready_i && !rd_pending) begin
                    if (stall_en && !ar_held && stall_rng[1:0] == 2'b00) begin
                        ar_held = 1'b1;                 // one wait cycle
                    end else begin
                        ar_ready_i = 1'b1;
                    end
                end
                if (rd_pending && r_ready_o && !r_valid_i) begin
                    if (stall_en && !r_held && stall_rng[3:2] == 2'b00) begin
                        r_held = 1'b1;
                    end else begin
                        r_valid_i = 1'b1;
                        r_data_i  = mem[rd_addr];
                    end
                end
                ar_hs = ar_valid_o && ar_ready_i;
                if (ar_hs) begin
                    rd_addr = ar_addr_o;
                end
                r_hs = r_valid_i && r_ready_o;
            end
        end
    end

    initial begin : stimulus
        addr_t               line_addr;                 // model line start
        logic [REPEAT_W-1:0] v_left;                    // model repeat countdown
        addr_t               f_start;
        word_t               f_len;
        logic [REPEAT_W-1:0] f_vrep;
        logic                f_blank;
        stim_rng       = SEED;
        stall_rng      = SEED;
        reset_i        = 1'b1;
        h_count_i      = '0;
        fetch_start_i  = 1'b0;
        end_of_line_i  = 1'b0;
        end_of_frame_i = 1'b0;
        vid_left_i     = hres_t'(VID_LEFT);
        for (int a = 0; a < 65536; a++) begin
            stim_rng = xorshift32(stim_rng);
            mem[a]   = stim_rng[15:0];
        end
        pick_config(0);                                 // loaded by reset as frame start
        repeat (RESET_CYCLES) @(negedge clk);
        reset_i = 1'b0;
        @(negedge clk);
        check_value(color_index_o, border_color_i ^ colorbase_i, "color index after reset");
        check_value(scanout_o, 1'b0, "scanout after reset");
        check_value(ar_valid_o, 1'b0, "ar_valid after reset");
        check_value(r_ready_o, 1'b0, "r_ready after reset");
        for (int f = 0; f < NUM_FRAMES; f++) begin
            f_start   = start_addr_i;
            f_len     = line_len_i;
            f_vrep    = v_repeat_i;
            f_blank   = blank_i;
            line_addr = f_start;
            v_left    = f_vrep;
            for (int l = 0; l < NUM_LINES; l++) begin
                build_line(line_addr);
                run_line(f, l, l == NUM_LINES - 1);
                if (f_blank) begin
                    line_addr = f_start;                // blank pins every line to the top
                    v_left    = f_vrep;
                end else if (v_left == '0) begin
                    v_left    = f_vrep;
                    line_addr = addr_t'(line_addr + f_len);
                end else begin
                    v_left = v_left - 1'b1;             // same source line again
                end
            end
        end
        @(negedge clk);
        end_of_line_i  = 1'b0;
        end_of_frame_i = 1'b0;
        $display("TEST PASS");
        $finish;
    end

    initial begin : watchdog
        #(WATCHDOG_NS);
        $display("simulation hung, the frames did not finish before the watchdog expired");
        $display("TEST FAIL");
        $fatal(1, "watchdog timeout");
    end

endmodule

/* src.f */
design/playfield_pkg.sv
design/scan_ctrl_if.sv
design/word_fetch.sv
design/scan_timer.sv
design/pixel_shifter.sv
design/playfield_top.sv
verif/playfield_tb.sv

/* Bender.yml */
package:
  name: playfield

sources:
  - design/playfield_pkg.sv
  - design/scan_ctrl_if.sv
  - design/word_fetch.sv
  - design/scan_timer.sv
  - design/pixel_shifter.sv
  - design/playfield_top.sv
  - target: test
    files:
      - verif/playfield_tb.sv
